//--- design/tdcHist_settings.svh
`ifndef TDCHIST_SETTINGS_SVH
`define TDCHIST_SETTINGS_SVH

// histogram geometry
`define PIXEL_NUM 4
`define BIN_NUM   16
`define COUNT_W   8

// raw word layout: overflow 9, pixel 8-7, bin 6-3, fine 2-0
`define HIT_W     10

// host bus
`define APB_AW    8

`endif

//--- design/tdcHistPkg.sv
`include "tdcHist_settings.svh"

package tdcHistPkg;

    typedef logic [$clog2(`PIXEL_NUM)-1:0] pixelT;
    typedef logic [$clog2(`BIN_NUM)-1:0]   binT;
    typedef logic [`COUNT_W-1:0]           countT;
    typedef logic [`HIT_W-1:0]             hitWordT;

    // pixel in the upper bits, bin below
    typedef logic [$clog2(`PIXEL_NUM)+$clog2(`BIN_NUM)-1:0] ramAddrT;

    typedef enum logic [1:0] {
        IDLE,
        CLEAR, // zeroing the memory
        ACCUM,
        DRAIN  // last hits still in the pipe
    } accStateT;

endpackage

//--- design/histRamIf.sv
`timescale 1ns/1ns

interface histRamIf;
    import tdcHistPkg::*;

    logic    wrEn;
    ramAddrT wrAddr;
    countT   wrData;
    ramAddrT rdAddr;
    countT   rdData; // one cycle after rdAddr

    modport accum (
        output wrEn, wrAddr, wrData, rdAddr,
        input  rdData
    );

    modport mem (
        input  wrEn, wrAddr, wrData, rdAddr,
        output rdData
    );

endinterface

//--- design/hitDecode.sv
`timescale 1ns/1ns
`include "tdcHist_settings.svh"

module hitDecode (
    input  logic                clk,
    input  logic                res,
    input  logic                hitValid,
    input  tdcHistPkg::hitWordT hitWord,
    output logic                decValid,
    output tdcHistPkg::pixelT   decPixel,
    output tdcHistPkg::binT     decBin
);
    import tdcHistPkg::*;

    localparam int OVF_BIT = `HIT_W - 1;
    localparam int PIX_LSB = OVF_BIT - $bits(pixelT);
    localparam int BIN_LSB = PIX_LSB - $bits(binT); // fine bits sit below this

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            decValid <= 1'b0;
        end else begin
            decValid <= hitValid && !hitWord[OVF_BIT]; // overflow words are lost here
        end
    end

    // field split, only meaningful with decValid
    always_ff @(posedge clk) begin
        decPixel <= hitWord[PIX_LSB +: $bits(pixelT)];
        decBin   <= hitWord[BIN_LSB +: $bits(binT)];
    end

endmodule

//--- design/histAccumulate.sv
`timescale 1ns/1ns

module histAccumulate (
    input  logic              clk,
    input  logic              res,
    input  logic              decValid,
    input  tdcHistPkg::pixelT decPixel,
    input  tdcHistPkg::binT   decBin,
    input  logic              startGo,
    input  logic              searchReq,
    histRamIf.accum           ram,
    output logic              searchGo,
    output logic              clearing,
    output logic              accumulating
);
    import tdcHistPkg::*;

    accStateT state;
    logic     drainCnt;
    logic     s1Valid;  // stage 1 waits for read data
    ramAddrT  s1Addr;
    logic     fwd;
    countT    oldCount;
    countT    newCount;

    assign ram.rdAddr   = {decPixel, decBin}; // read issued with the decoded hit
    assign fwd          = ram.wrEn && (ram.wrAddr == s1Addr); // stage 2 still writing it
    assign oldCount     = fwd ? ram.wrData : ram.rdData;
    assign newCount     = (oldCount == '1) ? oldCount : oldCount + 1'b1;
    assign clearing     = (state == CLEAR);
    assign accumulating = (state == ACCUM) || (state == DRAIN);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= IDLE;
            drainCnt <= 1'b0;
            searchGo <= 1'b0;
            s1Valid  <= 1'b0;
            ram.wrEn <= 1'b0;
        end else begin
            searchGo <= 1'b0;
            s1Valid  <= decValid && (state == ACCUM); // drop hits elsewhere
            case (state)
                IDLE: begin
                    if (startGo) state <= CLEAR;
                end
                CLEAR: begin
                    if (ram.wrAddr == '1) state <= ACCUM;
                end
                ACCUM: begin
                    if (searchReq) begin
                        state    <= DRAIN;
                        drainCnt <= 1'b0;
                    end
                end
                DRAIN: begin
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        state    <= IDLE;
                        searchGo <= 1'b1; // memory is settled now
                    end
                end
                default: state <= IDLE;
            endcase

            if (state == IDLE && startGo)
                ram.wrEn <= 1'b1; // first clear write
            else if (state == CLEAR && ram.wrAddr != '1)
                ram.wrEn <= 1'b1;
            else
                ram.wrEn <= s1Valid;
        end
    end

    // write address doubles as the clear counter
    always_ff @(posedge clk) begin
        s1Addr <= ram.rdAddr;
        if (state == CLEAR)
            ram.wrAddr <= ram.wrAddr + 1'b1;
        else if (state == IDLE)
            ram.wrAddr <= '0;
        else
            ram.wrAddr <= s1Addr;
        ram.wrData <= accumulating ? newCount : '0;
    end

endmodule

//--- design/histRam.sv
`timescale 1ns/1ns
`include "tdcHist_settings.svh"

module histRam (
    input  logic                clk,
    input  tdcHistPkg::ramAddrT pkAddr,
    histRamIf.mem               ram,
    output tdcHistPkg::countT   pkData
);
    import tdcHistPkg::*;

    countT mem [0:`PIXEL_NUM*`BIN_NUM-1];

    always_ff @(posedge clk) begin
        if (ram.wrEn) mem[ram.wrAddr] <= ram.wrData;

        // accumulator port is write-first on a collision
        if (ram.wrEn && (ram.wrAddr == ram.rdAddr))
            ram.rdData <= ram.wrData;
        else
            ram.rdData <= mem[ram.rdAddr];

        pkData <= mem[pkAddr]; // search port, no writes during a sweep
    end

endmodule

//--- design/peakFinder.sv
`timescale 1ns/1ns
`include "tdcHist_settings.svh"

module peakFinder (
    input  logic                clk,
    input  logic                res,
    input  logic                searchGo,
    input  logic                startGo,
    input  tdcHistPkg::pixelT   rdSel,
    input  tdcHistPkg::countT   pkData,
    output tdcHistPkg::ramAddrT pkAddr,
    output logic                searching,
    output logic                peaksValid,
    output tdcHistPkg::binT     peakBin,
    output tdcHistPkg::countT   peakCount
);
    import tdcHistPkg::*;

    logic    issuing;   // read addresses going out
    logic    dataValid; // pkData belongs to dataAddr
    ramAddrT dataAddr;
    pixelT   dataPixel;
    binT     dataBin;
    binT     peakBinR [`PIXEL_NUM];
    countT   peakCountR [`PIXEL_NUM];

    assign dataPixel = dataAddr[$bits(ramAddrT)-1 -: $bits(pixelT)];
    assign dataBin   = dataAddr[$bits(binT)-1:0];
    assign peakBin   = peakBinR[rdSel];
    assign peakCount = peakCountR[rdSel];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            issuing    <= 1'b0;
            pkAddr     <= '0;
            dataValid  <= 1'b0;
            searching  <= 1'b0;
            peaksValid <= 1'b0;
        end else begin
            dataValid <= issuing;
            if (searchGo) begin
                issuing    <= 1'b1;
                pkAddr     <= '0;
                searching  <= 1'b1;
                peaksValid <= 1'b0;
            end else if (issuing) begin
                pkAddr <= pkAddr + 1'b1;
                if (pkAddr == '1) issuing <= 1'b0;
            end

            // tail cycle, last bin of last pixel
            if (dataValid && dataAddr == '1) begin
                searching  <= 1'b0;
                peaksValid <= 1'b1;
            end
            if (startGo) peaksValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        dataAddr <= pkAddr;
        // bin 0 seeds the pixel, later bins must be strictly higher
        if (dataValid && (dataBin == '0 || pkData > peakCountR[dataPixel])) begin
            peakCountR[dataPixel] <= pkData;
            peakBinR[dataPixel]   <= dataBin;
        end
    end

endmodule

//--- design/apbHostPort.sv
`timescale 1ns/1ns
`include "tdcHist_settings.svh"

module apbHostPort (
    input  logic                clk,
    input  logic                res,
    input  logic                pSel,
    input  logic                pEnable,
    input  logic                pWrite,
    input  logic [`APB_AW-1:0]  pAddr,
    input  logic [31:0]         pWData,
    output logic [31:0]         pRData,
    output logic                pReady,
    output logic                pSlvErr,
    output logic                startGo,
    output logic                searchReq,
    output tdcHistPkg::pixelT   rdSel,
    input  logic                clearing,
    input  logic                accumulating,
    input  logic                searching,
    input  logic                peaksValid,
    input  tdcHistPkg::binT     peakBin,
    input  tdcHistPkg::countT   peakCount
);
    import tdcHistPkg::*;

    localparam logic [`APB_AW-1:0] CTRL_ADDR   = 'h00;
    localparam logic [`APB_AW-1:0] STATUS_ADDR = 'h04;
    localparam logic [`APB_AW-1:0] PEAK_BASE   = 'h10; // one word per pixel

    logic access;
    logic isCtrl;
    logic isStatus;
    logic isPeak;
    logic busy;
    logic ctrlWr;

    assign access   = pSel && pEnable;
    assign isCtrl   = (pAddr == CTRL_ADDR);
    assign isStatus = (pAddr == STATUS_ADDR);
    assign isPeak   = (pAddr >= PEAK_BASE) && (pAddr < PEAK_BASE + 4 * `PIXEL_NUM)
                      && (pAddr[1:0] == 2'b00);
    assign rdSel    = pAddr[2 +: $bits(pixelT)];
    assign busy     = clearing || accumulating || searching;
    assign ctrlWr   = access && pWrite && isCtrl;
    assign pReady   = 1'b1;
    assign pSlvErr  = access && !(isCtrl || isStatus || isPeak);

    always_comb begin
        pRData = '0;
        if (access && !pWrite) begin
            if (isStatus)
                pRData = {28'b0, peaksValid, searching, accumulating, clearing};
            else if (isPeak)
                pRData = {16'b0, peakCount, 4'b0, peakBin};
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            startGo   <= 1'b0;
            searchReq <= 1'b0;
        end else begin
            startGo   <= ctrlWr && pWData[0] && !busy; // only from idle
            searchReq <= ctrlWr && pWData[1] && accumulating;
        end
    end

endmodule

//--- design/tdcHistTop.sv
`timescale 1ns/1ns
`include "tdcHist_settings.svh"

module tdcHistTop (
    input  logic                clk,
    input  logic                res,
    input  logic                hitValid,
    input  tdcHistPkg::hitWordT hitWord,
    input  logic                pSel,
    input  logic                pEnable,
    input  logic                pWrite,
    input  logic [`APB_AW-1:0]  pAddr,
    input  logic [31:0]         pWData,
    output logic [31:0]         pRData,
    output logic                pReady,
    output logic                pSlvErr
);
    import tdcHistPkg::*;

    logic    decValid;
    pixelT   decPixel;
    binT     decBin;
    logic    startGo;
    logic    searchReq;
    logic    searchGo;
    logic    clearing;
    logic    accumulating;
    logic    searching;
    logic    peaksValid;
    ramAddrT pkAddr;
    countT   pkData;
    pixelT   rdSel;
    binT     peakBin;
    countT   peakCount;

    histRamIf ramBus ();

    hitDecode uDecode (
        .clk(clk), .res(res), .hitValid(hitValid), .hitWord(hitWord),
        .decValid(decValid), .decPixel(decPixel), .decBin(decBin)
    );

    histAccumulate uAccum (
        .clk(clk), .res(res), .decValid(decValid), .decPixel(decPixel),
        .decBin(decBin), .startGo(startGo), .searchReq(searchReq), .ram(ramBus.accum),
        .searchGo(searchGo), .clearing(clearing), .accumulating(accumulating)
    );

    histRam uRam (
        .clk(clk), .pkAddr(pkAddr), .ram(ramBus.mem), .pkData(pkData)
    );

    peakFinder uPeak (
        .clk(clk), .res(res), .searchGo(searchGo), .startGo(startGo), .rdSel(rdSel),
        .pkData(pkData), .pkAddr(pkAddr), .searching(searching), .peaksValid(peaksValid),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    apbHostPort uApb (
        .clk(clk), .res(res), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
        .pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady),
        .pSlvErr(pSlvErr), .startGo(startGo), .searchReq(searchReq), .rdSel(rdSel),
        .clearing(clearing), .accumulating(accumulating), .searching(searching),
        .peaksValid(peaksValid), .peakBin(peakBin), .peakCount(peakCount)
    );

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/1ns

module tbClock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic res
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        res = 1'b0; // held low from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        res = 1'b1;
    end

endmodule

//--- testbench/tbTdcHist.sv
`timescale 1ns/1ns
`include "tdcHist_settings.svh"

module tbTdcHist;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int LINE_CYCLES = 200; // watchdog budget per test line

    logic               clk;
    logic               res;
    logic               hitValid;
    logic [`HIT_W-1:0]  hitWord;
    logic               pSel;
    logic               pEnable;
    logic               pWrite;
    logic [`APB_AW-1:0] pAddr;
    logic [31:0]        pWData;
    logic [31:0]        pRData;
    logic               pReady;
    logic               pSlvErr;

    logic [7:0]  cmdQ [$];
    logic [31:0] argA [$];
    logic [31:0] argB [$];
    logic [31:0] argC [$];
    int          model [`PIXEL_NUM*`BIN_NUM]; // expected count per memory address
    logic        modelAccum;                  // model thinks the DUT accumulates
    logic        loaded;

    tbClock clockGen (.clk(clk), .res(res));

    tdcHistTop UUT (
        .clk(clk), .res(res), .hitValid(hitValid), .hitWord(hitWord),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData),
        .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr)
    );

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // setup cycle, access cycle, results sampled mid access
    task automatic apbAccess(input logic write, input logic [`APB_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic slvErr);
        @(posedge clk);
        #DRIVE_DELAY;
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = write;
        pAddr   = addr;
        pWData  = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        pEnable = 1'b1;
        @(negedge clk);
        rdata  = pRData;
        slvErr = pSlvErr;
        checkValue(pReady, 1, "pReady in access cycle");
        @(posedge clk);
        #DRIVE_DELAY;
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    // polls STATUS, seen collects every flag shown on the way
    task automatic waitStatus(input int bitIdx, output logic [31:0] seen);
        logic [31:0] data;
        logic        err;
        data = '0;
        seen = '0;
        while (!data[bitIdx]) begin
            apbAccess(1'b0, 'h04, 0, data, err);
            seen = seen | data;
        end
    endtask

    task automatic sendHits(input logic [`HIT_W-1:0] word, input int num);
        for (int i = 0; i < num; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            hitValid = 1'b1;
            hitWord  = word;
            // overflow words and hits outside accumulation are lost, counts saturate
            if (modelAccum && !word[`HIT_W-1] && model[word[`HIT_W-2:3]] < 255)
                model[word[`HIT_W-2:3]]++;
        end
    endtask

    task automatic stopHits();
        if (hitValid) begin
            @(posedge clk);
            #DRIVE_DELAY;
            hitValid = 1'b0;
        end
    endtask

    task automatic checkPeaks();
        logic [31:0] data;
        logic        err;
        int          best;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            best = 0;
            for (int b = 1; b < `BIN_NUM; b++)
                if (model[p*`BIN_NUM+b] > model[p*`BIN_NUM+best]) best = b; // ties keep lower bin
            apbAccess(1'b0, 'h10 + 4 * p, 0, data, err);
            checkValue(data, (model[p*`BIN_NUM+best] << 8) | best,
                       $sformatf("peak of pixel %0d", p));
            checkValue(err, 0, "pSlvErr on peak read");
        end
    endtask

    task automatic runLine(input int n);
        logic [31:0] data;
        logic [31:0] seen;
        logic        err;
        case (cmdQ[n])
            "H": sendHits(argA[n], argB[n]);
            "X": for (int i = 0; i < argA[n]; i++) sendHits($urandom, 1);
            "S": begin
                stopHits();
                apbAccess(1'b1, 'h00, 1, data, err);
                waitStatus(1, seen);
                if (!modelAccum) begin
                    foreach (model[a]) model[a] = 0; // start only taken from idle
                    modelAccum = 1'b1;
                    checkValue(seen[0], 1, "clearing flag during the clear");
                end
            end
            "Q": begin
                stopHits();
                apbAccess(1'b1, 'h00, 2, data, err);
                waitStatus(3, seen);
                checkValue(seen[2], 1, "searching flag during the search");
                modelAccum = 1'b0;
                checkPeaks();
            end
            default: begin // R and W
                stopHits();
                apbAccess(cmdQ[n] == "W", argA[n], argB[n], data, err);
                if (cmdQ[n] == "R") checkValue(data, argB[n], $sformatf("read of %h", argA[n]));
                checkValue(err, argC[n], $sformatf("pSlvErr at %h", argA[n]));
            end
        endcase
    endtask

    task automatic loadTests();
        int          fd;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("testbench/tdcHist_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/tdcHist_tests.txt");
            $display("** FAIL **");
            $fatal(1, "missing test file");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            a = 0;
            b = 0;
            c = 0;
            void'($sscanf(line, "%c %h %h %h", cmd, a, b, c));
            if (!(cmd inside {"H", "S", "Q", "R", "W", "X"})) begin
                $display("unknown command in test file: %s", line);
                $display("** FAIL **");
                $fatal(1, "bad test file");
            end
            cmdQ.push_back(cmd);
            argA.push_back(a);
            argB.push_back(b);
            argC.push_back(c);
        end
        $fclose(fd);
    endtask

    initial begin
        wait (loaded);
        #(cmdQ.size() * LINE_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped responding",
                 cmdQ.size() * LINE_CYCLES);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial begin
        hitValid   = 1'b0;
        hitWord    = '0;
        pSel       = 1'b0;
        pEnable    = 1'b0;
        pWrite     = 1'b0;
        pAddr      = '0;
        pWData     = '0;
        modelAccum = 1'b0;
        loaded     = 1'b0;
        void'($urandom(72779)); // fixes the random hit stream
        loadTests();
        loaded = 1'b1;
        wait (res === 1'b1);
        for (int n = 0; n < cmdQ.size(); n++) runLine(n);
        stopHits();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- testbench/tdcHist_tests.txt
# cmd a b c, all hex: H word repeat | S start | Q search and check peaks
# R addr data err | W addr data err | X number of random hits
H 0ab 3 0
S 0 0 0
Q 0 0 0
R 010 0 0
R 004 8 0
S 0 0 0
H 0ab 4 0
H 2ab 2 0
H 13a 2 0
H 003 1 0
H 00f 1 0
Q 0 0 0
R 014 405 0
S 0 0 0
H 1f8 12c 0
W 000 1 0
R 004 2 0
R 0ff 0 1
R 011 0 1
W 040 3 1
Q 0 0 0
R 01c ff0f 0
S 0 0 0
X c8 0 0
Q 0 0 0

//--- tb.f
+incdir+design
design/tdcHistPkg.sv
design/histRamIf.sv
design/hitDecode.sv
design/histAccumulate.sv
design/histRam.sv
design/peakFinder.sv
design/apbHostPort.sv
design/tdcHistTop.sv
testbench/tbClock.sv
testbench/tbTdcHist.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbTdcHist -f tb.f -o simTdcHist
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simTdcHist > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
